//--- verilog/sq_defs.svh
`ifndef SQ_DEFS_SVH
`define SQ_DEFS_SVH

// number of store queue entries
`define SQ_DEPTH 8

// entry index width, the wrapped pointer carries one more bit
`define SQ_IDX_W 3

// cache write path widths
`define ADDR_W 64
`define DATA_W 64
`define MASK_W 8

// rob id width, top bit is the rob wrap flag
`define ROB_ID_W 7

`endif

//--- verilog/sq_pkg.sv
`include "sq_defs.svh"
`default_nettype none

package sq_pkg;

    // entry index with the wrap flag on top
    typedef logic [`SQ_IDX_W:0] sq_ptr_t;

    // one bit per entry
    typedef logic [`SQ_DEPTH-1:0] sq_vec_t;

    typedef logic [`ROB_ID_W-1:0] rob_id_t;

    typedef enum logic [1:0] {
        SQ_FREE      = 2'd0,
        SQ_ALLOC     = 2'd1,
        SQ_COMMITTED = 2'd2
    } sq_state_e;

    // address fill from the address unit
    typedef struct packed {
        logic                valid;
        sq_ptr_t             sqid;
        logic [`ADDR_W-1:0]  addr;
        logic [`MASK_W-1:0]  mask;
    } agu_cmpl_t;

    // data fill from the data unit
    typedef struct packed {
        logic                valid;
        sq_ptr_t             sqid;
        logic [`DATA_W-1:0]  data;
    } dgu_cmpl_t;

    typedef struct packed {
        logic [`ADDR_W-1:0]  addr;
        logic [`DATA_W-1:0]  data;
        logic [`MASK_W-1:0]  mask;
    } dcache_write_t;

endpackage

`default_nettype wire

//--- verilog/sq_flush_range.sv
`include "sq_defs.svh"
`default_nettype none

module sq_flush_range (
    input  wire logic [`SQ_IDX_W-1:0]  flush_idx,
    input  wire logic [`SQ_IDX_W-1:0]  tail_idx,
    input  wire logic                  flush_valid,
    output logic      [`SQ_DEPTH-1:0]  flush_vec
);

    logic wrapped;

    // tail below the flush point means the range runs past the last entry
    assign wrapped = tail_idx < flush_idx;

    always_comb begin
        flush_vec = '0;
        if (flush_valid) begin
            for (int i = 0; i < `SQ_DEPTH; i++) begin
                if (wrapped) begin
                    flush_vec[i] = (i >= int'(flush_idx)) || (i < int'(tail_idx));
                end else begin
                    flush_vec[i] = (i >= int'(flush_idx)) && (i < int'(tail_idx));
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/sq_robid_cam.sv
`include "sq_defs.svh"
`default_nettype none

module sq_robid_cam
    import sq_pkg::*;
(
    input  wire logic     clock,
    input  wire logic     rst_n,
    input  wire sq_vec_t  alloc_vec,
    input  wire rob_id_t  disp_robid,
    input  wire logic     commit_valid,
    input  wire rob_id_t  commit_robid,
    output sq_vec_t       commit_vec
);

    rob_id_t robid_q [`SQ_DEPTH];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SQ_DEPTH; i++) begin
                robid_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `SQ_DEPTH; i++) begin
                if (alloc_vec[i]) begin
                    robid_q[i] <= disp_robid;
                end
            end
        end
    end

    // full compare including the rob wrap bit
    always_comb begin
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            commit_vec[i] = commit_valid && (robid_q[i] == commit_robid);
        end
    end

endmodule

`default_nettype wire

//--- verilog/sq_payload.sv
`include "sq_defs.svh"
`default_nettype none

module sq_payload
    import sq_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       rst_n,
    input  wire sq_vec_t    alloc_vec,
    input  wire agu_cmpl_t  agu_cmpl,
    input  wire dgu_cmpl_t  dgu_cmpl,
    input  wire sq_vec_t    head_oh,
    output sq_vec_t         filled_vec,
    output dcache_write_t   head_write
);

    logic [`ADDR_W-1:0]  addr_q [`SQ_DEPTH];
    logic [`MASK_W-1:0]  mask_q [`SQ_DEPTH];
    logic [`DATA_W-1:0]  data_q [`SQ_DEPTH];
    sq_vec_t             addr_done;
    sq_vec_t             data_done;
    sq_vec_t             agu_vec;
    sq_vec_t             dgu_vec;

    // decode fill sqid into the target entry, wrap flag not needed here
    always_comb begin
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            agu_vec[i] = agu_cmpl.valid && (agu_cmpl.sqid[`SQ_IDX_W-1:0] == i);
            dgu_vec[i] = dgu_cmpl.valid && (dgu_cmpl.sqid[`SQ_IDX_W-1:0] == i);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            if (agu_vec[i]) begin
                addr_q[i] <= agu_cmpl.addr;
                mask_q[i] <= agu_cmpl.mask;
            end
            if (dgu_vec[i]) begin
                data_q[i] <= dgu_cmpl.data;
            end
        end
    end

    // a new allocation starts with both fills pending
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            addr_done <= '0;
            data_done <= '0;
        end else begin
            addr_done <= (addr_done & ~alloc_vec) | agu_vec;
            data_done <= (data_done & ~alloc_vec) | dgu_vec;
        end
    end

    assign filled_vec = addr_done & data_done;

    always_comb begin
        head_write = '0;
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            if (head_oh[i]) begin
                head_write.addr = addr_q[i];
                head_write.data = data_q[i];
                head_write.mask = mask_q[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/sq_ctrl.sv
`include "sq_defs.svh"
`default_nettype none

module sq_ctrl
    import sq_pkg::*;
(
    input  wire logic     clock,
    input  wire logic     rst_n,
    input  wire logic     disp_valid,
    output logic          can_alloc,
    output sq_ptr_t       sqid,
    input  wire logic     flush_valid,
    input  wire sq_ptr_t  flush_sqid,
    input  wire sq_vec_t  commit_vec,
    input  wire sq_vec_t  filled_vec,
    input  wire logic     dc_ready,
    output logic          dc_valid,
    output sq_vec_t       alloc_vec,
    output sq_vec_t       head_oh
);

    sq_ptr_t               tail_ptr;
    sq_ptr_t               head_ptr;
    sq_state_e             entry_state [`SQ_DEPTH];
    logic [`SQ_IDX_W-1:0]  tail_idx;
    logic [`SQ_IDX_W-1:0]  head_idx;
    logic                  full;
    logic                  alloc_fire;
    logic                  deq_fire;
    logic                  flush_all;
    sq_vec_t               range_vec;
    sq_vec_t               flush_vec;
    sq_vec_t               deq_vec;

    assign tail_idx = tail_ptr[`SQ_IDX_W-1:0];
    assign head_idx = head_ptr[`SQ_IDX_W-1:0];

    // same index with opposite wrap flags means every entry is taken
    assign full = (tail_idx == head_idx) && (tail_ptr[`SQ_IDX_W] != head_ptr[`SQ_IDX_W]);

    assign can_alloc  = ~full;
    assign sqid       = tail_ptr;
    assign alloc_fire = disp_valid & can_alloc & ~flush_valid;

    always_comb begin
        alloc_vec = '0;
        head_oh   = '0;
        alloc_vec[tail_idx] = alloc_fire;
        head_oh[head_idx]   = 1'b1;
    end

    // head leaves once it is committed and both fills are in
    assign dc_valid = (entry_state[head_idx] == SQ_COMMITTED) && filled_vec[head_idx];
    assign deq_fire = dc_valid & dc_ready;
    assign deq_vec  = deq_fire ? head_oh : '0;

    sq_flush_range i_sq_flush_range (
        .flush_valid (flush_valid),
        .flush_idx   (flush_sqid[`SQ_IDX_W-1:0]),
        .tail_idx    (tail_idx),
        .flush_vec   (range_vec)
    );

    // equal indices with different flags: the flush covers the whole ring
    assign flush_all = flush_valid
                     && (flush_sqid[`SQ_IDX_W-1:0] == tail_idx)
                     && (flush_sqid[`SQ_IDX_W] != tail_ptr[`SQ_IDX_W]);
    assign flush_vec = range_vec | {`SQ_DEPTH{flush_all}};

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            tail_ptr <= '0;
            head_ptr <= '0;
        end else begin
            // redirect rewinds the tail and drops any allocation this cycle
            if (flush_valid) begin
                tail_ptr <= flush_sqid;
            end else if (alloc_fire) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (deq_fire) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SQ_DEPTH; i++) begin
                entry_state[i] <= SQ_FREE;
            end
        end else begin
            for (int i = 0; i < `SQ_DEPTH; i++) begin
                if (flush_vec[i]) begin
                    entry_state[i] <= SQ_FREE;
                end else if (alloc_vec[i]) begin
                    entry_state[i] <= SQ_ALLOC;
                end else if (commit_vec[i] && (entry_state[i] == SQ_ALLOC)) begin
                    // stale rob ids in free entries are ignored here
                    entry_state[i] <= SQ_COMMITTED;
                end else if (deq_vec[i]) begin
                    entry_state[i] <= SQ_FREE;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/store_queue.sv
`include "sq_defs.svh"
`default_nettype none

module store_queue
    import sq_pkg::*;
(
    input  wire logic          clock,
    input  wire logic          rst_n,
    // dispatch
    input  wire logic          disp_valid,
    input  wire rob_id_t       disp_robid,
    output logic               can_alloc,
    output sq_ptr_t            sqid,
    // fills
    input  wire agu_cmpl_t     agu_cmpl,
    input  wire dgu_cmpl_t     dgu_cmpl,
    // commit and redirect
    input  wire logic          commit_valid,
    input  wire rob_id_t       commit_robid,
    input  wire logic          flush_valid,
    input  wire sq_ptr_t       flush_sqid,
    // dcache write port
    output logic               dc_valid,
    input  wire logic          dc_ready,
    output dcache_write_t      dc_write
);

    sq_vec_t alloc_vec;
    sq_vec_t head_oh;
    sq_vec_t commit_vec;
    sq_vec_t filled_vec;

    sq_ctrl i_sq_ctrl (
        .clock       (clock),
        .rst_n       (rst_n),
        .disp_valid  (disp_valid),
        .can_alloc   (can_alloc),
        .sqid        (sqid),
        .flush_valid (flush_valid),
        .flush_sqid  (flush_sqid),
        .commit_vec  (commit_vec),
        .filled_vec  (filled_vec),
        .dc_ready    (dc_ready),
        .dc_valid    (dc_valid),
        .alloc_vec   (alloc_vec),
        .head_oh     (head_oh)
    );

    sq_payload i_sq_payload (
        .clock       (clock),
        .rst_n       (rst_n),
        .alloc_vec   (alloc_vec),
        .agu_cmpl    (agu_cmpl),
        .dgu_cmpl    (dgu_cmpl),
        .head_oh     (head_oh),
        .filled_vec  (filled_vec),
        .head_write  (dc_write)
    );

    sq_robid_cam i_sq_robid_cam (
        .clock        (clock),
        .rst_n        (rst_n),
        .alloc_vec    (alloc_vec),
        .disp_robid   (disp_robid),
        .commit_valid (commit_valid),
        .commit_robid (commit_robid),
        .commit_vec   (commit_vec)
    );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // 40 ns period
    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // reset held for 16 cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/tb_store_queue.sv
`include "sq_defs.svh"
`default_nettype none

module tb_store_queue
    import sq_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // all tests together take well under 800 cycles
    localparam int MAX_CYCLES = 3000;

    logic          clock;
    logic          rst_n;
    logic          disp_valid;
    rob_id_t       disp_robid;
    logic          can_alloc;
    sq_ptr_t       sqid;
    agu_cmpl_t     agu_cmpl;
    dgu_cmpl_t     dgu_cmpl;
    logic          commit_valid;
    rob_id_t       commit_robid;
    logic          flush_valid;
    sq_ptr_t       flush_sqid;
    logic          dc_valid;
    logic          dc_ready;
    dcache_write_t dc_write;

    integer        seed = 32'h9bf42cc0;
    int            errors = 0;
    int            checks = 0;
    int            writes = 0;
    int            cycles = 0;
    sq_ptr_t       exp_sqid = '0;
    rob_id_t       next_rob = '0;
    logic          held = 1'b0;
    dcache_write_t held_write;

    // live stores in program order and what each entry was given
    sq_ptr_t              live_q [$];
    rob_id_t              mdl_rob [`SQ_DEPTH];
    logic                 mdl_commit [`SQ_DEPTH];
    logic [`ADDR_W-1:0]   mdl_addr [`SQ_DEPTH];
    logic [`DATA_W-1:0]   mdl_data [`SQ_DEPTH];
    logic [`MASK_W-1:0]   mdl_mask [`SQ_DEPTH];

    tb_clock_gen i_tb_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    store_queue i_store_queue (
        .clock        (clock),
        .rst_n        (rst_n),
        .disp_valid   (disp_valid),
        .disp_robid   (disp_robid),
        .can_alloc    (can_alloc),
        .sqid         (sqid),
        .agu_cmpl     (agu_cmpl),
        .dgu_cmpl     (dgu_cmpl),
        .commit_valid (commit_valid),
        .commit_robid (commit_robid),
        .flush_valid  (flush_valid),
        .flush_sqid   (flush_sqid),
        .dc_valid     (dc_valid),
        .dc_ready     (dc_ready),
        .dc_write     (dc_write)
    );

    // expected cache write for the store at the head of the model
    function automatic dcache_write_t expected_write(input sq_ptr_t id);
        dcache_write_t w;
        w.addr = mdl_addr[id[`SQ_IDX_W-1:0]];
        w.data = mdl_data[id[`SQ_IDX_W-1:0]];
        w.mask = mdl_mask[id[`SQ_IDX_W-1:0]];
        return w;
    endfunction

    task automatic check_val(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
        checks++;
        if (got !== exp) begin
            $display("** Error: %s is %0h, expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s finished, %0d errors so far", name, errors);
    endtask

    // all stimulus tasks start and end on a falling edge
    task automatic alloc_store(output sq_ptr_t id);
        while (!can_alloc) @(negedge clock);
        check_val("sqid", sqid, exp_sqid);
        id = exp_sqid;
        disp_valid = 1'b1;
        disp_robid = next_rob;
        mdl_rob[id[`SQ_IDX_W-1:0]]    = next_rob;
        mdl_commit[id[`SQ_IDX_W-1:0]] = 1'b0;
        live_q.push_back(id);
        @(negedge clock);
        disp_valid = 1'b0;
        exp_sqid   = exp_sqid + 1'b1;
        next_rob   = next_rob + 1'b1;
    endtask

    task automatic fill_addr(input sq_ptr_t id);
        agu_cmpl.valid = 1'b1;
        agu_cmpl.sqid  = id;
        agu_cmpl.addr  = {$random(seed), $random(seed)};
        agu_cmpl.mask  = $random(seed);
        mdl_addr[id[`SQ_IDX_W-1:0]] = agu_cmpl.addr;
        mdl_mask[id[`SQ_IDX_W-1:0]] = agu_cmpl.mask;
        @(negedge clock);
        agu_cmpl.valid = 1'b0;
    endtask

    task automatic fill_data(input sq_ptr_t id);
        dgu_cmpl.valid = 1'b1;
        dgu_cmpl.sqid  = id;
        dgu_cmpl.data  = {$random(seed), $random(seed)};
        mdl_data[id[`SQ_IDX_W-1:0]] = dgu_cmpl.data;
        @(negedge clock);
        dgu_cmpl.valid = 1'b0;
    endtask

    task automatic commit_store(input sq_ptr_t id);
        commit_valid = 1'b1;
        commit_robid = mdl_rob[id[`SQ_IDX_W-1:0]];
        mdl_commit[id[`SQ_IDX_W-1:0]] = 1'b1;
        @(negedge clock);
        commit_valid = 1'b0;
    endtask

    task automatic complete_store(input sq_ptr_t id);
        fill_addr(id);
        fill_data(id);
        commit_store(id);
    endtask

    task automatic flush_from(input sq_ptr_t id);
        flush_valid = 1'b1;
        flush_sqid  = id;
        @(negedge clock);
        flush_valid = 1'b0;
        while (live_q.size() > 0 && live_q[$] != id) begin
            void'(live_q.pop_back());
        end
        void'(live_q.pop_back());
        exp_sqid = id;
    endtask

    task automatic wait_drain();
        while (live_q.size() != 0) @(negedge clock);
    endtask

    // random back-pressure from the cache
    always @(negedge clock) begin
        if (rst_n) begin
            dc_ready = ($random(seed) & 3) != 0;
        end
    end

    // sample 10 ns before the rising edge where a transfer would happen
    always begin
        sq_ptr_t head;
        @(negedge clock);
        #10;
        if (rst_n) begin
            if (held) begin
                check_val("dc_valid", dc_valid, 1'b1);
                check_val("dc_write", dc_write, held_write);
            end
            held       = dc_valid && !dc_ready;
            held_write = dc_write;
            if (dc_valid && dc_ready) begin
                if (live_q.size() == 0) begin
                    $display("cache write seen while no store was pending");
                    errors++;
                end else begin
                    head = live_q.pop_front();
                    if (!mdl_commit[head[`SQ_IDX_W-1:0]]) begin
                        $display("store %0h left the queue before its commit", head);
                        errors++;
                    end
                    check_val("dc_write", dc_write, expected_write(head));
                    writes++;
                end
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the queue did not drain", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        sq_ptr_t ids [8];
        int      ops [10];
        int      j;
        int      tmp;
        disp_valid   = 1'b0;
        disp_robid   = '0;
        agu_cmpl     = '0;
        dgu_cmpl     = '0;
        commit_valid = 1'b0;
        commit_robid = '0;
        flush_valid  = 1'b0;
        flush_sqid   = '0;
        dc_ready     = 1'b0;
        wait (rst_n);
        @(negedge clock);

        check_val("can_alloc", can_alloc, 1'b1);
        check_val("dc_valid", dc_valid, 1'b0);
        check_val("sqid", sqid, 0);
        report_test("reset");

        // two passes over the ring give sqid 0..7 and then 8..15 with the wrap flag
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 8; i++) alloc_store(ids[i]);
            check_val("can_alloc", can_alloc, 1'b0);
            for (int i = 0; i < 8; i++) complete_store(ids[i]);
            wait_drain();
        end
        check_val("sqid", sqid, 0);
        report_test("alloc_wrap");

        // shuffled fill order with commits in rob order
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < 5; i++) alloc_store(ids[i]);
            for (int k = 0; k < 10; k++) ops[k] = k;
            for (int k = 9; k > 0; k--) begin
                j      = $unsigned($random(seed)) % (k + 1);
                tmp    = ops[k];
                ops[k] = ops[j];
                ops[j] = tmp;
            end
            for (int k = 0; k < 10; k++) begin
                if (ops[k][0]) fill_data(ids[ops[k] >> 1]);
                else fill_addr(ids[ops[k] >> 1]);
            end
            for (int i = 0; i < 5; i++) commit_store(ids[i]);
            wait_drain();
        end
        report_test("random_fill_order");

        // head committed but missing its data blocks younger stores
        for (int i = 0; i < 3; i++) alloc_store(ids[i]);
        fill_addr(ids[0]);
        commit_store(ids[0]);
        complete_store(ids[1]);
        complete_store(ids[2]);
        repeat (10) @(negedge clock);
        check_val("pending stores", live_q.size(), 3);
        fill_data(ids[0]);
        wait_drain();
        // uncommitted head blocks a committed younger store
        alloc_store(ids[0]);
        alloc_store(ids[1]);
        fill_addr(ids[0]);
        fill_data(ids[0]);
        complete_store(ids[1]);
        repeat (10) @(negedge clock);
        check_val("pending stores", live_q.size(), 2);
        commit_store(ids[0]);
        wait_drain();
        report_test("head_blocking");

        // flush across the ring end while two older committed stores wait on the head data
        for (int i = 0; i < 8; i++) alloc_store(ids[i]);
        fill_addr(ids[0]);
        commit_store(ids[0]);
        complete_store(ids[1]);
        for (int i = 2; i < 8; i++) begin
            fill_addr(ids[i]);
            fill_data(ids[i]);
        end
        flush_from(ids[2]);
        check_val("sqid", sqid, ids[2]);
        check_val("pending stores", live_q.size(), 2);
        fill_data(ids[0]);
        for (int i = 2; i < 4; i++) alloc_store(ids[i]);
        for (int i = 2; i < 4; i++) complete_store(ids[i]);
        wait_drain();
        repeat (10) @(negedge clock);
        report_test("flush");

        $display("%0d checks, %0d cache writes, %0d errors", checks, writes, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verilog
verilog/sq_pkg.sv
verilog/sq_flush_range.sv
verilog/sq_robid_cam.sv
verilog/sq_payload.sv
verilog/sq_ctrl.sv
verilog/store_queue.sv
verification/tb_clock_gen.sv
verification/tb_store_queue.sv

//--- run_sim.sh
#!/bin/sh
# build the store queue testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_store_queue \
    -o sim_store_queue &&
    ./obj_dir/sim_store_queue | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
